/* verilog/text_pkg.sv */
package text_pkg;

    // ==============================
    // Bus and glyph geometry
    // ==============================
    localparam int APB_ADDR_W  = 12;  // Word address.
    localparam int APB_DATA_W  = 32;
    localparam int GLYPH_W     = 8;
    localparam int GLYPH_H     = 8;
    localparam int FONT_ADDR_W = 9;   // Glyph code times 8 plus row.

    // Top two address bits.
    typedef enum logic [1:0] {
        REGION_REGS = 2'b00,
        REGION_TEXT = 2'b01,  // 1024 character codes.
        REGION_FONT = 2'b10,  // 64 glyphs of 8 rows.
        REGION_NONE = 2'b11
    } region_e;

    typedef enum logic [9:0] {
        REG_CTRL   = 10'd0,  // Bit 0 enable, bit 1 cursor enable.
        REG_CURSOR = 10'd1,  // Row in 15:8, column in 7:0.
        REG_FG     = 10'd2,
        REG_BG     = 10'd3
    } reg_e;

    typedef enum logic {
        ST_IDLE,
        ST_RAM_WAIT
    } apb_state_e;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

endpackage

/* verilog/text_if.sv */
`timescale 1ns/1ps

// ==============================
// Display settings from the control block
// ==============================
interface disp_if;
    logic           enable;
    logic           cursor_en;
    logic [7:0]     cursor_col;
    logic [7:0]     cursor_row;
    text_pkg::rgb_t fg;
    text_pkg::rgb_t bg;

    modport ctrl (output enable, cursor_en, cursor_col, cursor_row, fg, bg);
    modport render (input enable, cursor_en, cursor_col, cursor_row, fg, bg);
endinterface

// ==============================
// Pixel timing
// ==============================
interface vid_timing_if #(
    parameter int XW = 6,
    parameter int YW = 5
);
    logic          de;
    logic          hsync_n;
    logic          vsync_n;
    logic [XW-1:0] px;  // Position inside the active area.
    logic [YW-1:0] py;

    modport src (output de, hsync_n, vsync_n, px, py);
    modport sink (input de, hsync_n, vsync_n, px, py);
endinterface

// One read/write memory port, read data one cycle after en.
interface ram_port_if #(
    parameter int AW = 10,
    parameter int DW = 8
);
    logic          en;
    logic          we;
    logic [AW-1:0] addr;
    logic [DW-1:0] wdata;
    logic [DW-1:0] rdata;

    modport master (output en, we, addr, wdata, input rdata);
    modport mem (input en, we, addr, wdata, output rdata);
endinterface

/* verilog/text_ctrl.sv */
`timescale 1ns/1ps

module text_ctrl (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  logic                            psel_i,
    input  logic                            penable_i,
    input  logic                            pwrite_i,
    input  logic [text_pkg::APB_ADDR_W-1:0] paddr_i,
    input  logic [text_pkg::APB_DATA_W-1:0] pwdata_i,
    output logic [text_pkg::APB_DATA_W-1:0] prdata_o,
    output logic                            pready_o,
    output logic                            pslverr_o,
    disp_if.ctrl                            disp_o,
    ram_port_if.master                      text_o,
    ram_port_if.master                      font_o
);
    localparam int DW = text_pkg::APB_DATA_W;

    text_pkg::region_e             region;
    text_pkg::reg_e                reg_sel;
    text_pkg::apb_state_e          state;
    logic [text_pkg::APB_ADDR_W-3:0] offset;
    logic                          access;
    logic                          is_mem;
    logic                          bad;
    logic                          mem_rd;
    logic [1:0]                    ctrl_q;
    logic [15:0]                   cursor_q;
    text_pkg::rgb_t                fg_q;
    text_pkg::rgb_t                bg_q;
    logic [DW-1:0]                 reg_rdata;

    // ==============================
    // Decode
    // ==============================
    assign region  = text_pkg::region_e'(paddr_i[text_pkg::APB_ADDR_W-1 -: 2]);
    assign offset  = paddr_i[text_pkg::APB_ADDR_W-3:0];
    assign reg_sel = text_pkg::reg_e'(offset);
    assign access  = psel_i && penable_i;
    assign is_mem  = (region == text_pkg::REGION_TEXT) || (region == text_pkg::REGION_FONT);
    assign bad     = (region == text_pkg::REGION_NONE) ||
                     ((region == text_pkg::REGION_REGS) && (offset > 10'd3));
    assign mem_rd  = access && is_mem && !pwrite_i && (state == text_pkg::ST_IDLE);

    // Memory request goes out in the first access cycle.
    assign text_o.en    = access && (state == text_pkg::ST_IDLE) &&
                          (region == text_pkg::REGION_TEXT);
    assign text_o.we    = pwrite_i;
    assign text_o.addr  = offset;
    assign text_o.wdata = pwdata_i[7:0];
    assign font_o.en    = access && (state == text_pkg::ST_IDLE) &&
                          (region == text_pkg::REGION_FONT);
    assign font_o.we    = pwrite_i;
    assign font_o.addr  = offset[text_pkg::FONT_ADDR_W-1:0];
    assign font_o.wdata = pwdata_i[7:0];

    assign pready_o  = access && !mem_rd;  // One wait state on memory reads.
    assign pslverr_o = access && bad;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state <= text_pkg::ST_IDLE;
        end else begin
            case (state)
                text_pkg::ST_IDLE:     if (mem_rd) state <= text_pkg::ST_RAM_WAIT;
                text_pkg::ST_RAM_WAIT: state <= text_pkg::ST_IDLE;
                default:               state <= text_pkg::ST_IDLE;
            endcase
        end
    end

    // ==============================
    // Registers
    // ==============================
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_q   <= '0;
            cursor_q <= '0;
            fg_q     <= '0;
            bg_q     <= '0;
        end else if (access && pwrite_i && (region == text_pkg::REGION_REGS)) begin
            case (reg_sel)
                text_pkg::REG_CTRL:   ctrl_q   <= pwdata_i[1:0];
                text_pkg::REG_CURSOR: cursor_q <= pwdata_i[15:0];
                text_pkg::REG_FG:     fg_q     <= pwdata_i[23:0];
                text_pkg::REG_BG:     bg_q     <= pwdata_i[23:0];
                default:              ;  // Unmapped offset.
            endcase
        end
    end

    always_comb begin
        reg_rdata = '0;
        if (region == text_pkg::REGION_REGS) begin
            case (reg_sel)
                text_pkg::REG_CTRL:   reg_rdata = DW'(ctrl_q);
                text_pkg::REG_CURSOR: reg_rdata = DW'(cursor_q);
                text_pkg::REG_FG:     reg_rdata = DW'(fg_q);
                text_pkg::REG_BG:     reg_rdata = DW'(bg_q);
                default:              reg_rdata = '0;
            endcase
        end
    end

    always_comb begin
        prdata_o = reg_rdata;
        if (state == text_pkg::ST_RAM_WAIT) begin
            prdata_o = (region == text_pkg::REGION_TEXT) ? DW'(text_o.rdata)
                                                         : DW'(font_o.rdata);
        end
    end

    assign disp_o.enable     = ctrl_q[0];
    assign disp_o.cursor_en  = ctrl_q[1];
    assign disp_o.cursor_col = cursor_q[7:0];
    assign disp_o.cursor_row = cursor_q[15:8];
    assign disp_o.fg         = fg_q;
    assign disp_o.bg         = bg_q;

    a_pready_in_access: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pready_o |-> psel_i && penable_i);

    a_no_req_in_hole: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (text_o.en || font_o.en) |-> region != text_pkg::REGION_NONE);

endmodule

/* verilog/sync_gen.sv */
`timescale 1ns/1ps

module sync_gen #(
    parameter int H_ACTIVE = 64,
    parameter int H_FRONT  = 4,
    parameter int H_SYNC   = 8,
    parameter int H_BACK   = 4,
    parameter int V_ACTIVE = 32,
    parameter int V_FRONT  = 2,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 2
) (
    input  logic      clk_i,
    input  logic      arst_n_i,
    vid_timing_if.src tim_o
);
    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int HW      = $clog2(H_TOTAL);
    localparam int VW      = $clog2(V_TOTAL);
    localparam int XW      = $clog2(H_ACTIVE);
    localparam int YW      = $clog2(V_ACTIVE);

    localparam logic [HW-1:0] H_LAST  = HW'(H_TOTAL - 1);
    localparam logic [HW-1:0] H_ACT   = HW'(H_ACTIVE);
    localparam logic [HW-1:0] H_S_BEG = HW'(H_ACTIVE + H_FRONT);
    localparam logic [HW-1:0] H_S_END = HW'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam logic [VW-1:0] V_LAST  = VW'(V_TOTAL - 1);
    localparam logic [VW-1:0] V_ACT   = VW'(V_ACTIVE);
    localparam logic [VW-1:0] V_S_BEG = VW'(V_ACTIVE + V_FRONT);
    localparam logic [VW-1:0] V_S_END = VW'(V_ACTIVE + V_FRONT + V_SYNC);

    logic [HW-1:0] hcnt;
    logic [VW-1:0] vcnt;

    // Active area first, then front porch, sync and back porch.
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (hcnt == H_LAST) begin
            hcnt <= '0;
            vcnt <= (vcnt == V_LAST) ? '0 : vcnt + 1'b1;
        end else begin
            hcnt <= hcnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tim_o.de      <= 1'b0;
            tim_o.hsync_n <= 1'b1;
            tim_o.vsync_n <= 1'b1;
            tim_o.px      <= '0;
            tim_o.py      <= '0;
        end else begin
            tim_o.de      <= (hcnt < H_ACT) && (vcnt < V_ACT);
            tim_o.hsync_n <= !((hcnt >= H_S_BEG) && (hcnt < H_S_END));
            tim_o.vsync_n <= !((vcnt >= V_S_BEG) && (vcnt < V_S_END));
            tim_o.px      <= hcnt[XW-1:0];  // Don't care outside the active area.
            tim_o.py      <= vcnt[YW-1:0];
        end
    end

    a_cnt_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (hcnt <= H_LAST) && (vcnt <= V_LAST));

endmodule

/* verilog/text_ram.sv */
`timescale 1ns/1ps

module text_ram #(
    parameter int AW = 10,
    parameter int DW = 8
) (
    input  logic          clk_i,
    input  logic [AW-1:0] rd_addr_i,
    output logic [DW-1:0] rd_data_o,
    ram_port_if.mem       bus_i
);
    logic [DW-1:0] mem [2**AW];

    // Port A, CPU side.
    always_ff @(posedge clk_i) begin
        if (bus_i.en) begin
            if (bus_i.we) begin
                mem[bus_i.addr] <= bus_i.wdata;
            end else begin
                bus_i.rdata <= mem[bus_i.addr];
            end
        end
    end

    // Port B, video side. Reads every cycle.
    always_ff @(posedge clk_i) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

/* verilog/glyph_render.sv */
`timescale 1ns/1ps

module glyph_render #(
    parameter int H_ACTIVE = 64,
    parameter int V_ACTIVE = 32
) (
    input  logic                             clk_i,
    input  logic                             arst_n_i,
    vid_timing_if.sink                       tim_i,
    disp_if.render                           disp_i,
    output logic [9:0]                       text_addr_o,
    input  logic [7:0]                       text_data_i,
    output logic [text_pkg::FONT_ADDR_W-1:0] font_addr_o,
    input  logic [text_pkg::GLYPH_W-1:0]     font_data_i,
    output logic                             hsync_n_o,
    output logic                             vsync_n_o,
    output logic                             de_o,
    output text_pkg::rgb_t                   rgb_o
);
    localparam int COLS = H_ACTIVE / text_pkg::GLYPH_W;
    localparam int XW   = $clog2(H_ACTIVE);
    localparam int YW   = $clog2(V_ACTIVE);
    localparam int GXW  = $clog2(text_pkg::GLYPH_W);
    localparam int GYW  = $clog2(text_pkg::GLYPH_H);

    logic [XW-GXW-1:0] col;
    logic [YW-GYW-1:0] row;
    logic              de1, hs1, vs1;
    logic              de2, hs2, vs2;
    logic [GXW-1:0]    xbit1, xbit2;
    logic [GYW-1:0]    yrow1;
    logic              hit1, hit2;
    logic              pix_on;
    text_pkg::rgb_t    fg_c, bg_c;

    // ==============================
    // Stage 1, character fetch
    // ==============================
    assign col         = tim_i.px[XW-1:GXW];
    assign row         = tim_i.py[YW-1:GYW];
    assign text_addr_o = 10'(row * COLS + col);

    // ==============================
    // Stage 2, glyph row fetch
    // ==============================
    assign font_addr_o = {text_data_i[text_pkg::FONT_ADDR_W-GYW-1:0], yrow1};

    // Stage 3, pixel select. MSB is the leftmost pixel.
    assign pix_on = font_data_i[text_pkg::GLYPH_W - 1 - int'(xbit2)];
    assign fg_c   = hit2 ? disp_i.bg : disp_i.fg;  // Cursor cell is inverted.
    assign bg_c   = hit2 ? disp_i.fg : disp_i.bg;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            de1       <= 1'b0;
            hs1       <= 1'b1;
            vs1       <= 1'b1;
            de2       <= 1'b0;
            hs2       <= 1'b1;
            vs2       <= 1'b1;
            de_o      <= 1'b0;
            hsync_n_o <= 1'b1;
            vsync_n_o <= 1'b1;
            rgb_o     <= '0;
        end else begin
            de1       <= tim_i.de;
            hs1       <= tim_i.hsync_n;
            vs1       <= tim_i.vsync_n;
            de2       <= de1;
            hs2       <= hs1;
            vs2       <= vs1;
            de_o      <= de2;
            hsync_n_o <= hs2;
            vsync_n_o <= vs2;
            rgb_o     <= (de2 && disp_i.enable) ? (pix_on ? fg_c : bg_c) : '0;
        end
    end

    // Pixel payload travels alongside.
    always_ff @(posedge clk_i) begin
        xbit1 <= tim_i.px[GXW-1:0];
        yrow1 <= tim_i.py[GYW-1:0];
        hit1  <= disp_i.cursor_en && (8'(col) == disp_i.cursor_col) &&
                 (8'(row) == disp_i.cursor_row);
        xbit2 <= xbit1;
        hit2  <= hit1;
    end

    a_blank_black: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !de_o |-> rgb_o == '0);

endmodule

/* verilog/text_display.sv */
`timescale 1ns/1ps

module text_display #(
    parameter int H_ACTIVE = 64,
    parameter int H_FRONT  = 4,
    parameter int H_SYNC   = 8,
    parameter int H_BACK   = 4,
    parameter int V_ACTIVE = 32,
    parameter int V_FRONT  = 2,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 2
) (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  logic                            psel_i,
    input  logic                            penable_i,
    input  logic                            pwrite_i,
    input  logic [text_pkg::APB_ADDR_W-1:0] paddr_i,
    input  logic [text_pkg::APB_DATA_W-1:0] pwdata_i,
    output logic [text_pkg::APB_DATA_W-1:0] prdata_o,
    output logic                            pready_o,
    output logic                            pslverr_o,
    output logic                            hsync_n_o,
    output logic                            vsync_n_o,
    output logic                            de_o,
    output logic [23:0]                     rgb_o
);
    logic [9:0]                       text_addr;
    logic [7:0]                       text_data;
    logic [text_pkg::FONT_ADDR_W-1:0] font_addr;
    logic [7:0]                       font_data;

    disp_if disp ();
    vid_timing_if #(.XW($clog2(H_ACTIVE)), .YW($clog2(V_ACTIVE))) tim ();
    ram_port_if #(.AW(10), .DW(8)) text_bus ();
    ram_port_if #(.AW(text_pkg::FONT_ADDR_W), .DW(8)) font_bus ();

    // ==============================
    // CPU side
    // ==============================
    text_ctrl u_ctrl (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .disp_o    (disp),
        .text_o    (text_bus),
        .font_o    (font_bus)
    );

    text_ram #(.AW(10), .DW(8)) u_text (
        .clk_i     (clk_i),
        .rd_addr_i (text_addr),
        .rd_data_o (text_data),
        .bus_i     (text_bus)
    );

    text_ram #(.AW(text_pkg::FONT_ADDR_W), .DW(8)) u_font (
        .clk_i     (clk_i),
        .rd_addr_i (font_addr),
        .rd_data_o (font_data),
        .bus_i     (font_bus)
    );

    // ==============================
    // Video side
    // ==============================
    sync_gen #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) u_sync (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .tim_o    (tim)
    );

    glyph_render #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE)
    ) u_render (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .tim_i       (tim),
        .disp_i      (disp),
        .text_addr_o (text_addr),
        .text_data_i (text_data),
        .font_addr_o (font_addr),
        .font_data_i (font_data),
        .hsync_n_o   (hsync_n_o),
        .vsync_n_o   (vsync_n_o),
        .de_o        (de_o),
        .rgb_o       (rgb_o)
    );

endmodule

/* tests/tb_props.svh */
`ifndef TB_PROPS_SVH
`define TB_PROPS_SVH

// ==============================
// Expected video
// ==============================
function automatic logic [23:0] expected_pixel(input int h, input int v);
    int         col;
    int         row;
    logic [7:0] code;
    logic [7:0] bits;
    logic       pix;
    logic       hit;
    if ((h >= H_ACTIVE) || (v >= V_ACTIVE) || !sh_ctrl[0]) begin
        return '0;  // Blanking or display off.
    end
    col  = h / 8;
    row  = v / 8;
    code = sh_text[10'(row * COLS + col)];
    bits = sh_font[{code[5:0], 3'(v % 8)}];
    pix  = bits[3'(7 - h % 8)];  // MSB is the leftmost pixel.
    hit  = sh_ctrl[1] && (col == int'(sh_cursor[7:0])) && (row == int'(sh_cursor[15:8]));
    if (hit) begin
        return pix ? sh_bg : sh_fg;
    end
    return pix ? sh_fg : sh_bg;
endfunction

function automatic logic expected_de(input int h, input int v);
    return (h < H_ACTIVE) && (v < V_ACTIVE);
endfunction

function automatic logic expected_hsync_n(input int h);
    return !((h >= H_ACTIVE + H_FRONT) && (h < H_ACTIVE + H_FRONT + H_SYNC));
endfunction

function automatic logic expected_vsync_n(input int v);
    return !((v >= V_ACTIVE + V_FRONT) && (v < V_ACTIVE + V_FRONT + V_SYNC));
endfunction

// ==============================
// Checks
// ==============================
a_pixel: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    check_en |-> rgb_o == expected_pixel(h_pos, v_pos))
    else report_mismatch("rgb_o", 32'($sampled(rgb_o)),
                         32'(expected_pixel($sampled(h_pos), $sampled(v_pos))));

a_de: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    synced |-> de_o == expected_de(h_pos, v_pos))
    else report_mismatch("de_o", 32'($sampled(de_o)),
                         32'(expected_de($sampled(h_pos), $sampled(v_pos))));

a_hsync: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    synced |-> hsync_n_o == expected_hsync_n(h_pos))
    else report_mismatch("hsync_n_o", 32'($sampled(hsync_n_o)),
                         32'(expected_hsync_n($sampled(h_pos))));

a_vsync: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    synced |-> vsync_n_o == expected_vsync_n(v_pos))
    else report_mismatch("vsync_n_o", 32'($sampled(vsync_n_o)),
                         32'(expected_vsync_n($sampled(v_pos))));

// Blanking is always black.
a_blank: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !de_o |-> rgb_o == '0)
    else report_mismatch("rgb_o", 32'($sampled(rgb_o)), 32'h0);

`endif

/* tests/tb_text_display.sv */
`timescale 1ns/1ps

module tb_text_display;

    localparam int H_ACTIVE = 64;
    localparam int H_FRONT  = 4;
    localparam int H_SYNC   = 8;
    localparam int H_BACK   = 4;
    localparam int V_ACTIVE = 32;
    localparam int V_FRONT  = 2;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 2;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int COLS     = H_ACTIVE / 8;
    localparam int ROWS     = V_ACTIVE / 8;

    logic        clk_i;
    logic        arst_n_i;
    logic        psel_i;
    logic        penable_i;
    logic        pwrite_i;
    logic [11:0] paddr_i;
    logic [31:0] pwdata_i;
    logic [31:0] prdata_o;
    logic        pready_o;
    logic        pslverr_o;
    logic        hsync_n_o;
    logic        vsync_n_o;
    logic        de_o;
    logic [23:0] rgb_o;

    logic [7:0]  sh_text [1024];
    logic [7:0]  sh_font [512];
    logic [1:0]  sh_ctrl;
    logic [15:0] sh_cursor;
    logic [23:0] sh_fg;
    logic [23:0] sh_bg;
    int          h_pos;     // Position of the output sampled at this edge.
    int          v_pos;
    logic        synced;
    logic        vs_seen;
    logic        check_en;
    int          err_cnt;

    text_display #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
    ) UUT (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .hsync_n_o (hsync_n_o),
        .vsync_n_o (vsync_n_o),
        .de_o      (de_o),
        .rgb_o     (rgb_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // ==============================
    // Screen position tracking
    // ==============================
    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            synced  <= 1'b0;
            vs_seen <= 1'b1;
            h_pos   <= 0;
            v_pos   <= 0;
        end else begin
            vs_seen <= vsync_n_o;
            if (!synced && vs_seen && !vsync_n_o) begin
                synced <= 1'b1;  // Column 0 of the first sync line seen here.
                h_pos  <= 1;
                v_pos  <= V_ACTIVE + V_FRONT;
            end else if (h_pos == H_TOTAL - 1) begin
                h_pos <= 0;
                v_pos <= (v_pos == V_TOTAL - 1) ? 0 : v_pos + 1;
            end else begin
                h_pos <= h_pos + 1;
            end
        end
    end

    task automatic halt_with_error(input string msg);
        err_cnt++;
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] exp);
        halt_with_error($sformatf("mismatch at %0t: %s got 0x%0h expected 0x%0h",
                                  $time, sig, got, exp));
    endtask

    // ==============================
    // APB transfers
    // ==============================
    task automatic apb_xfer(input logic wr, input logic [11:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err, output int waits);
        logic done;
        @(posedge clk_i);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= wr;
        paddr_i   <= addr;
        pwdata_i  <= wdata;
        @(posedge clk_i);
        penable_i <= 1'b1;
        waits = -1;
        done  = 1'b0;
        while (!done) begin
            @(posedge clk_i);
            waits++;
            if (pready_o) begin
                done = 1'b1;
            end else if (waits >= 16) begin
                halt_with_error("APB transfer timed out waiting for pready_o");
            end
        end
        rdata = prdata_o;
        err   = pslverr_o;
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    function automatic logic [31:0] shadow_value(input logic [11:0] addr);
        case (addr[11:10])
            2'b01:   return 32'(sh_text[addr[9:0]]);
            2'b10:   return 32'(sh_font[addr[8:0]]);
            default: begin
                case (addr[1:0])
                    2'd0:    return 32'(sh_ctrl);
                    2'd1:    return 32'(sh_cursor);
                    2'd2:    return 32'(sh_fg);
                    default: return 32'(sh_bg);
                endcase
            end
        endcase
    endfunction

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] wdata);
        logic [31:0] rd;
        logic        err;
        int          waits;
        apb_xfer(1'b1, addr, wdata, rd, err, waits);
        assert (err == 1'b0) else report_mismatch("pslverr_o", 32'(err), 32'h0);
        assert (waits == 0) else report_mismatch("write wait states", 32'(waits), 32'h0);
        case (addr[11:10])
            2'b01:   sh_text[addr[9:0]] = wdata[7:0];
            2'b10:   sh_font[addr[8:0]] = wdata[7:0];
            default: begin
                case (addr[1:0])
                    2'd0:    sh_ctrl   = wdata[1:0];
                    2'd1:    sh_cursor = wdata[15:0];
                    2'd2:    sh_fg     = wdata[23:0];
                    default: sh_bg     = wdata[23:0];
                endcase
            end
        endcase
    endtask

    task automatic read_check(input logic [11:0] addr);
        logic [31:0] rd;
        logic        err;
        int          waits;
        int          exp_waits;
        exp_waits = (addr[11:10] == 2'b00) ? 0 : 1;  // Memory reads take one wait state.
        apb_xfer(1'b0, addr, 32'h0, rd, err, waits);
        assert (err == 1'b0) else report_mismatch("pslverr_o", 32'(err), 32'h0);
        assert (waits == exp_waits)
            else report_mismatch("read wait states", 32'(waits), 32'(exp_waits));
        assert (rd == shadow_value(addr)) else report_mismatch("prdata_o", rd, shadow_value(addr));
    endtask

    task automatic bad_access(input logic wr, input logic [11:0] addr);
        logic [31:0] rd;
        logic        err;
        int          waits;
        apb_xfer(wr, addr, $urandom(), rd, err, waits);
        assert (err == 1'b1) else report_mismatch("pslverr_o", 32'(err), 32'h1);
        assert (waits == 0) else report_mismatch("error wait states", 32'(waits), 32'h0);
    endtask

    // Arms the pixel checks for exactly one frame, from its first pixel.
    task automatic check_frame();
        int waited;
        waited = 0;
        while (!(synced && (h_pos == H_TOTAL - 1) && (v_pos == V_TOTAL - 1))) begin
            @(posedge clk_i);
            waited++;
            if (waited > 2 * H_TOTAL * V_TOTAL) begin
                halt_with_error("no frame start found on vsync_n_o");
            end
        end
        check_en <= 1'b1;
        repeat (H_TOTAL * V_TOTAL) @(posedge clk_i);
        check_en <= 1'b0;
    endtask

    `include "tb_props.svh"

    // ==============================
    // Stimulus
    // ==============================
    initial begin
        int a;
        void'($urandom(32'hf03f));
        arst_n_i  = 1'b0;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        check_en  = 1'b0;
        err_cnt   = 0;
        sh_ctrl   = '0;
        sh_cursor = '0;
        sh_fg     = '0;
        sh_bg     = '0;
        repeat (16) @(posedge clk_i);
        assert (hsync_n_o && vsync_n_o && !de_o && (rgb_o == '0) && !pready_o && !pslverr_o)
            else halt_with_error("outputs are not at their reset values during reset");
        arst_n_i <= 1'b1;

        for (a = 0; a < 4; a++) begin
            read_check(12'(a));  // Zero after reset.
            apb_write(12'(a), $urandom());
            read_check(12'(a));
        end
        repeat (8) begin
            a = $urandom_range(1023);
            apb_write(12'h400 | 12'(a), $urandom());
            read_check(12'h400 | 12'(a));
            a = $urandom_range(511);
            apb_write(12'h800 | 12'(a), $urandom());
            read_check(12'h800 | 12'(a));
        end

        bad_access(1'b1, 12'hC00 | 12'($urandom_range(1023)));
        bad_access(1'b0, 12'hC00 | 12'($urandom_range(1023)));
        bad_access(1'b1, 12'h005);
        bad_access(1'b0, 12'h005);
        for (a = 0; a < 4; a++) begin
            read_check(12'(a));
        end

        apb_write(12'h000, 32'h0);
        for (a = 0; a < COLS * ROWS; a++) begin
            apb_write(12'h400 | 12'(a), $urandom());
        end
        for (a = 0; a < 512; a++) begin
            apb_write(12'h800 | 12'(a), $urandom());
        end
        apb_write(12'h002, $urandom());
        apb_write(12'h003, $urandom());
        check_frame();  // Display off.
        apb_write(12'h000, 32'h1);
        check_frame();
        apb_write(12'h001, {16'h0, 8'($urandom_range(ROWS - 1)), 8'($urandom_range(COLS - 1))});
        apb_write(12'h000, 32'h3);
        check_frame();

        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            halt_with_error("errors were recorded during the run");
        end
    end

endmodule

/* build.f */
+incdir+tests
verilog/text_pkg.sv
verilog/text_if.sv
verilog/text_ctrl.sv
verilog/sync_gen.sv
verilog/text_ram.sv
verilog/glyph_render.sv
verilog/text_display.sv
tests/tb_text_display.sv

/* Makefile */
TOP = tb_text_display

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module text_display

sim:
	verilator --binary --timing --assert -j 0 -f build.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
